//--- dacfifo_wr_top.f
+incdir+hw
hw/dacfifo_stream_pkg.sv
hw/dacfifo_avl_pkg.sv
hw/dacfifo_beat_packer.sv
hw/dacfifo_word_buffer.sv
hw/dacfifo_avl_writer.sv
hw/dacfifo_wr_ctrl.sv
hw/dacfifo_wr_top.sv
testbench/dacfifo_wr_checks.sv
testbench/dacfifo_wr_tb.sv

//--- Bender.yml
package:
  name: dacfifo_wr

sources:
  - include_dirs:
      - hw
    files:
      - hw/dacfifo_stream_pkg.sv
      - hw/dacfifo_avl_pkg.sv
      - hw/dacfifo_beat_packer.sv
      - hw/dacfifo_word_buffer.sv
      - hw/dacfifo_avl_writer.sv
      - hw/dacfifo_wr_ctrl.sv
      - hw/dacfifo_wr_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/dacfifo_wr_checks.sv
      - testbench/dacfifo_wr_tb.sv

//--- testbench/dacfifo_wr_tb.sv
// **********************************************************************
// testbench for the DAC buffer write path
// runs three transfers with random dma gaps and avalon stalls,
// the checker beside the DUT does the comparisons
// **********************************************************************

module dacfifo_wr_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import dacfifo_stream_pkg::*;
  import dacfifo_avl_pkg::*;

  localparam int TOTAL_BEATS    = 40 + 13 + 8 * 22;
  localparam int TIMEOUT_CYCLES = 20 * (TOTAL_BEATS + 100);

  logic      avl_clk;
  logic      avl_reset;
  dma_beat_t dma_beat;
  logic      dma_valid;
  logic      dma_ready;
  logic      dma_xfer_req;
  avl_cmd_t  avl_cmd;
  logic      avl_write;
  logic      avl_ready;
  avl_last_t avl_last;
  logic      done_req;
  logic      done_ack;
  integer    seed;
  int        check_errors;
  int        pending;
  int        tb_errors;
  int        stall_left;

  dacfifo_wr_top dacfifo_wr_top_inst (
    .avl_clk      (avl_clk),
    .avl_reset    (avl_reset),
    .dma_beat     (dma_beat),
    .dma_valid    (dma_valid),
    .dma_ready    (dma_ready),
    .dma_xfer_req (dma_xfer_req),
    .avl_cmd      (avl_cmd),
    .avl_write    (avl_write),
    .avl_ready    (avl_ready),
    .avl_last     (avl_last),
    .done_req     (done_req),
    .done_ack     (done_ack)
  );

  dacfifo_wr_checks dacfifo_wr_checks_inst (
    .avl_clk      (avl_clk),
    .avl_reset    (avl_reset),
    .dma_beat     (dma_beat),
    .dma_valid    (dma_valid),
    .dma_ready    (dma_ready),
    .dma_xfer_req (dma_xfer_req),
    .avl_cmd      (avl_cmd),
    .avl_write    (avl_write),
    .avl_ready    (avl_ready),
    .avl_last     (avl_last),
    .done_req     (done_req),
    .done_ack     (done_ack),
    .errors       (check_errors),
    .pending      (pending)
  );

  initial begin
    avl_clk = 1'b0;
    forever #4 avl_clk = ~avl_clk;
  end

  // long stalls now and then so the buffer fills and dma_ready drops
  always @(posedge avl_clk) begin
    if (stall_left > 0) begin
      avl_ready  <= 1'b0;
      stall_left <= stall_left - 1;
    end else if (($random(seed) & 63) == 0) begin
      avl_ready  <= 1'b0;
      stall_left <= 96 + ($random(seed) & 127);
    end else begin
      avl_ready <= 1'b1;
    end
  end

  // reader side of the four-phase handoff
  task automatic acknowledge_done();
    while (done_req !== 1'b1) @(posedge avl_clk);
    repeat ($random(seed) & 3) @(posedge avl_clk);
    done_ack <= 1'b1;
    while (done_req !== 1'b0) @(posedge avl_clk);
    done_ack <= 1'b0;
    repeat (3) @(posedge avl_clk);
  endtask

  task automatic run_transfer(input int nbeats);
    int sent;
    sent = 0;
    dma_xfer_req <= 1'b1;
    while (sent < nbeats) begin
      @(posedge avl_clk);
      if (dma_valid && dma_ready) begin
        sent++;
      end
      if (sent == nbeats) begin
        dma_valid    <= 1'b0;
        dma_xfer_req <= 1'b0;
      end else if (!dma_valid || dma_ready) begin
        // a pending beat holds until it is taken
        dma_valid     <= (($random(seed) & 3) != 0);
        dma_beat.data <= {$random(seed), $random(seed)};
        dma_beat.last <= (sent == nbeats - 1);
      end
    end
    acknowledge_done();
  endtask

  initial begin
    seed         = 32'hb55b;
    tb_errors    = 0;
    stall_left   = 0;
    avl_reset    = 1'b1;
    dma_beat     = '0;
    dma_valid    = 1'b0;
    dma_xfer_req = 1'b0;
    avl_ready    = 1'b0;
    done_ack     = 1'b0;
    repeat (5) @(posedge avl_clk);
    avl_reset <= 1'b0;
    repeat (3) @(posedge avl_clk);
    run_transfer(40);
    run_transfer(13);
    // 22 words over 20 addresses, so the address wraps
    run_transfer(8 * 22);
    repeat (10) @(posedge avl_clk);
    if (pending != 0) begin
      $display("[ERROR] %0t: %0d accepted beats were never written", $time, pending);
      tb_errors++;
    end
    $display("error count: %0d", check_errors + tb_errors);
    if (check_errors + tb_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge avl_clk);
    $display("[ERROR] %0t: timeout after %0d cycles, the transfers did not finish",
             $time, TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- testbench/dacfifo_wr_checks.sv
// **********************************************************************
// checker for the DAC buffer write path, sits beside the DUT
// keeps a queue of accepted beats and checks every accepted write,
// the address sequence, stalls, reset values and the done handshake
// **********************************************************************

`include "dacfifo_defines.svh"

module dacfifo_wr_checks (
  input  logic                          avl_clk,
  input  logic                          avl_reset,
  input  dacfifo_stream_pkg::dma_beat_t dma_beat,
  input  logic                          dma_valid,
  input  logic                          dma_ready,
  input  logic                          dma_xfer_req,
  input  dacfifo_avl_pkg::avl_cmd_t     avl_cmd,
  input  logic                          avl_write,
  input  logic                          avl_ready,
  input  dacfifo_avl_pkg::avl_last_t    avl_last,
  input  logic                          done_req,
  input  logic                          done_ack,
  output int                            errors,
  output int                            pending
);

  timeunit 1ns;
  timeprecision 100ps;

  import dacfifo_stream_pkg::*;
  import dacfifo_avl_pkg::*;

  localparam int BEAT_W     = `DACFIFO_DMA_DATA_WIDTH;
  localparam int RATIO      = `DACFIFO_MEM_RATIO;
  localparam int BYTES      = `DACFIFO_AVL_BYTE_WIDTH;
  localparam int BEAT_BYTES = BYTES / RATIO;
  localparam int ADDR_W     = `DACFIFO_AVL_ADDRESS_WIDTH;
  localparam logic [ADDR_W-1:0] BASE  = ADDR_W'(`DACFIFO_AVL_BASE_ADDRESS);
  localparam logic [ADDR_W-1:0] LIMIT = ADDR_W'(`DACFIFO_AVL_ADDRESS_LIMIT);

  dma_beat_t         beats [$];
  logic [ADDR_W-1:0] next_addr;
  // next write opens a transfer, so it goes to the base
  logic              first_write;
  logic              last_written;
  // dma_ready must stay low until a new request is seen
  logic              hold_ready_low;
  avl_last_t         last_rec;
  logic              reset_d;
  logic              stall_d;
  logic              done_req_d;
  logic              done_ack_d;
  logic              xfer_req_d;
  avl_cmd_t          cmd_d;

  initial begin
    errors         = 0;
    pending        = 0;
    next_addr      = BASE;
    first_write    = 1'b1;
    last_written   = 1'b0;
    hold_ready_low = 1'b1;
    reset_d        = 1'b0;
    stall_d        = 1'b0;
    done_req_d     = 1'b0;
    done_ack_d     = 1'b0;
    xfer_req_d     = 1'b0;
  end

  task automatic report_mismatch(input string name, input logic [511:0] expected,
                                 input logic [511:0] actual);
    $display("[ERROR] %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("[ERROR] %0t: %s", $time, what);
    errors++;
  endtask

  // ********************************************************************
  // one accepted write against the next beats of the reference queue
  // ********************************************************************

  task automatic check_write();
    dma_beat_t         beat;
    logic [BYTES-1:0]  exp_be;
    logic [ADDR_W-1:0] exp_addr;
    logic              is_last;
    int                n;
    n        = 0;
    is_last  = 1'b0;
    exp_be   = '0;
    exp_addr = first_write ? BASE : next_addr;
    while (n < RATIO && !is_last && beats.size() != 0) begin
      beat = beats.pop_front();
      assert (avl_cmd.data[n*BEAT_W +: BEAT_W] === beat.data)
        else report_mismatch($sformatf("avl_cmd.data lane %0d", n), beat.data,
                             avl_cmd.data[n*BEAT_W +: BEAT_W]);
      exp_be[n*BEAT_BYTES +: BEAT_BYTES] = '1;
      is_last = beat.last;
      n++;
    end
    if (n < RATIO && !is_last) begin
      report_failure("write accepted with fewer beats than a word holds");
    end
    assert (avl_cmd.address === exp_addr)
      else report_mismatch("avl_cmd.address", exp_addr, avl_cmd.address);
    assert (avl_cmd.byteenable === exp_be)
      else report_mismatch("avl_cmd.byteenable", exp_be, avl_cmd.byteenable);
    next_addr   = (exp_addr == LIMIT) ? BASE : exp_addr + 1'b1;
    first_write = is_last;
    if (is_last) begin
      last_written        = 1'b1;
      hold_ready_low      = 1'b1;
      last_rec.address    = exp_addr;
      last_rec.byteenable = exp_be;
    end
  endtask

  always @(posedge avl_clk) begin
    // outputs one edge into reset and right after it
    if (reset_d) begin
      assert (dma_ready === 1'b0) else report_mismatch("dma_ready", 0, dma_ready);
      assert (avl_write === 1'b0) else report_mismatch("avl_write", 0, avl_write);
      assert (done_req === 1'b0) else report_mismatch("done_req", 0, done_req);
    end
    if (avl_reset) begin
      beats.delete();
      first_write    = 1'b1;
      last_written   = 1'b0;
      hold_ready_low = 1'b1;
    end else begin
      if (stall_d) begin
        assert (avl_write === 1'b1) else report_mismatch("avl_write", 1, avl_write);
        assert (avl_cmd.address === cmd_d.address)
          else report_mismatch("avl_cmd.address", cmd_d.address, avl_cmd.address);
        assert (avl_cmd.data === cmd_d.data)
          else report_mismatch("avl_cmd.data", cmd_d.data, avl_cmd.data);
        assert (avl_cmd.byteenable === cmd_d.byteenable)
          else report_mismatch("avl_cmd.byteenable", cmd_d.byteenable, avl_cmd.byteenable);
      end
      if (hold_ready_low) begin
        assert (dma_ready === 1'b0)
          else report_failure("dma_ready went high before a new transfer request");
      end
      if (dma_xfer_req && !xfer_req_d && !done_ack && !done_req) begin
        hold_ready_low = 1'b0;
      end
      if (dma_valid && dma_ready) begin
        beats.push_back(dma_beat);
      end
      if (avl_write && avl_ready) begin
        check_write();
      end
      if (done_req && !done_req_d) begin
        assert (last_written) else report_failure("done_req rose before the final write");
        last_written = 1'b0;
      end
      if (!done_req && done_req_d) begin
        assert (done_ack_d) else report_failure("done_req fell while done_ack was low");
      end
      if (done_req) begin
        assert (avl_last.address === last_rec.address)
          else report_mismatch("avl_last.address", last_rec.address, avl_last.address);
        assert (avl_last.byteenable === last_rec.byteenable)
          else report_mismatch("avl_last.byteenable", last_rec.byteenable,
                               avl_last.byteenable);
      end
    end
    reset_d    = avl_reset;
    stall_d    = avl_write && !avl_ready;
    cmd_d      = avl_cmd;
    done_req_d = done_req;
    done_ack_d = done_ack;
    xfer_req_d = dma_xfer_req;
    pending    = beats.size();
  end

endmodule

//--- hw/dacfifo_wr_top.sv
// ******************************************************************
// write side of the DAC buffer
// dma beats are packed, buffered and written to ddr over avalon
// ******************************************************************

module dacfifo_wr_top (
  input  logic                          avl_clk,
  input  logic                          avl_reset,
  input  dacfifo_stream_pkg::dma_beat_t dma_beat,
  input  logic                          dma_valid,
  output logic                          dma_ready,
  input  logic                          dma_xfer_req,
  output dacfifo_avl_pkg::avl_cmd_t     avl_cmd,
  output logic                          avl_write,
  input  logic                          avl_ready,
  output dacfifo_avl_pkg::avl_last_t    avl_last,
  output logic                          done_req,
  input  logic                          done_ack
);

  import dacfifo_stream_pkg::*;

  logic       clear;
  logic       beat_en;
  logic       almost_full;
  logic       last_done;
  fifo_word_t word;
  logic       word_push;
  fifo_word_t head;
  logic       not_empty;
  logic       pop;

  // ****************************************************************
  // control
  // ****************************************************************

  dacfifo_wr_ctrl dacfifo_wr_ctrl_inst (
    .avl_clk      (avl_clk),
    .avl_reset    (avl_reset),
    .dma_xfer_req (dma_xfer_req),
    .dma_valid    (dma_valid),
    .almost_full  (almost_full),
    .last_done    (last_done),
    .dma_ready    (dma_ready),
    .beat_en      (beat_en),
    .clear        (clear),
    .done_req     (done_req),
    .done_ack     (done_ack)
  );

  // ****************************************************************
  // datapath
  // ****************************************************************

  dacfifo_beat_packer dacfifo_beat_packer_inst (
    .avl_clk   (avl_clk),
    .avl_reset (avl_reset),
    .clear     (clear),
    .beat_en   (beat_en),
    .dma_beat  (dma_beat),
    .word      (word),
    .word_push (word_push)
  );

  dacfifo_word_buffer dacfifo_word_buffer_inst (
    .avl_clk     (avl_clk),
    .avl_reset   (avl_reset),
    .clear       (clear),
    .word        (word),
    .word_push   (word_push),
    .pop         (pop),
    .head        (head),
    .not_empty   (not_empty),
    .almost_full (almost_full)
  );

  dacfifo_avl_writer dacfifo_avl_writer_inst (
    .avl_clk   (avl_clk),
    .avl_reset (avl_reset),
    .clear     (clear),
    .head      (head),
    .not_empty (not_empty),
    .pop       (pop),
    .avl_cmd   (avl_cmd),
    .avl_write (avl_write),
    .avl_ready (avl_ready),
    .avl_last  (avl_last),
    .last_done (last_done)
  );

endmodule

//--- hw/dacfifo_wr_ctrl.sv
// ******************************************************************
// transfer control for the write path
// starts a transfer on a rising dma_xfer_req, gates the dma input and
// runs the four-phase done_req/done_ack handoff at the end
// ******************************************************************

module dacfifo_wr_ctrl (
  input  logic avl_clk,
  input  logic avl_reset,
  input  logic dma_xfer_req,
  input  logic dma_valid,
  input  logic almost_full,
  input  logic last_done,
  output logic dma_ready,
  output logic beat_en,
  output logic clear,
  output logic done_req,
  input  logic done_ack
);

  typedef enum logic [1:0] {
    st_idle,
    st_fill,
    st_drain,
    st_handoff
  } state_t;

  state_t state;
  logic   xfer_req_d;
  logic   xfer_start;

  // a new transfer only while the reader has released done_ack
  assign xfer_start = dma_xfer_req & ~xfer_req_d & ~done_ack;
  assign clear      = (state == st_idle) & xfer_start;
  assign dma_ready  = (state == st_fill) & ~almost_full;
  assign beat_en    = dma_valid & dma_ready;

  always_ff @(posedge avl_clk) begin
    if (avl_reset) begin
      state      <= st_idle;
      xfer_req_d <= 1'b0;
      done_req   <= 1'b0;
    end else begin
      xfer_req_d <= dma_xfer_req;
      case (state)
        st_idle: begin
          if (xfer_start) begin
            state <= st_fill;
          end
        end
        // the last write may finish before the dma drops its request
        st_fill: begin
          if (last_done) begin
            state    <= st_handoff;
            done_req <= 1'b1;
          end else if (!dma_xfer_req) begin
            state <= st_drain;
          end
        end
        st_drain: begin
          if (last_done) begin
            state    <= st_handoff;
            done_req <= 1'b1;
          end
        end
        st_handoff: begin
          if (done_req) begin
            if (done_ack) begin
              done_req <= 1'b0;
            end
          end else if (!done_ack) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

//--- hw/dacfifo_avl_writer.sv
// ******************************************************************
// avalon write master draining the word buffer into ddr
// one word per write, address wraps from the limit back to the base
// ******************************************************************

`include "dacfifo_defines.svh"

module dacfifo_avl_writer (
  input  logic                           avl_clk,
  input  logic                           avl_reset,
  input  logic                           clear,
  input  dacfifo_stream_pkg::fifo_word_t head,
  input  logic                           not_empty,
  output logic                           pop,
  output dacfifo_avl_pkg::avl_cmd_t      avl_cmd,
  output logic                           avl_write,
  input  logic                           avl_ready,
  output dacfifo_avl_pkg::avl_last_t     avl_last,
  output logic                           last_done
);

  localparam int ADDR_W     = `DACFIFO_AVL_ADDRESS_WIDTH;
  localparam int BYTES      = `DACFIFO_AVL_BYTE_WIDTH;
  localparam int BEAT_BYTES = BYTES / `DACFIFO_MEM_RATIO;

  logic [ADDR_W-1:0]                  cmd_address;
  logic [`DACFIFO_AVL_DATA_WIDTH-1:0] cmd_data;
  logic [BYTES-1:0]                   cmd_be;
  logic                               cmd_last;
  logic [BYTES-1:0]                   head_be;
  logic                               accept;
  logic                               load;

  // low (index+1) beats worth of bytes, a full word gives all ones
  function automatic logic [BYTES-1:0] last_byteenable(
    input logic [`DACFIFO_BEAT_INDEX_WIDTH-1:0] index
  );
    int unsigned nbytes;
    nbytes = (int'(index) + 1) * BEAT_BYTES;
    return ~({BYTES{1'b1}} << nbytes);
  endfunction

  assign head_be = head.last ? last_byteenable(head.last_index) : '1;
  assign accept  = avl_write & avl_ready;
  assign load    = ~avl_write & not_empty & ~clear;
  // the loaded word stays at the head until its write is taken
  assign pop     = accept;

  always_ff @(posedge avl_clk) begin
    if (avl_reset || clear) begin
      avl_write   <= 1'b0;
      cmd_address <= ADDR_W'(`DACFIFO_AVL_BASE_ADDRESS);
      last_done   <= 1'b0;
    end else begin
      last_done <= accept & cmd_last;
      if (accept) begin
        avl_write <= 1'b0;
        if (cmd_address == ADDR_W'(`DACFIFO_AVL_ADDRESS_LIMIT)) begin
          cmd_address <= ADDR_W'(`DACFIFO_AVL_BASE_ADDRESS);
        end else begin
          cmd_address <= cmd_address + 1'b1;
        end
      end else if (load) begin
        avl_write <= 1'b1;
      end
    end
  end

  always_ff @(posedge avl_clk) begin
    if (load) begin
      cmd_data <= head.data;
      cmd_be   <= head_be;
      cmd_last <= head.last;
    end
    if (accept && cmd_last) begin
      avl_last.address    <= cmd_address;
      avl_last.byteenable <= cmd_be;
    end
  end

  assign avl_cmd.address    = cmd_address;
  assign avl_cmd.data       = cmd_data;
  assign avl_cmd.byteenable = cmd_be;

endmodule

//--- hw/dacfifo_word_buffer.sv
// ******************************************************************
// single-clock circular buffer of packed words
// head is read combinationally, almost_full throttles the dma side
// ******************************************************************

`include "dacfifo_defines.svh"

module dacfifo_word_buffer (
  input  logic                           avl_clk,
  input  logic                           avl_reset,
  input  logic                           clear,
  input  dacfifo_stream_pkg::fifo_word_t word,
  input  logic                           word_push,
  input  logic                           pop,
  output dacfifo_stream_pkg::fifo_word_t head,
  output logic                           not_empty,
  output logic                           almost_full
);

  import dacfifo_stream_pkg::*;

  // depth must be a power of two, pointers wrap on overflow
  localparam int DEPTH = `DACFIFO_BUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  fifo_word_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  always_ff @(posedge avl_clk) begin
    if (word_push) begin
      mem[wr_ptr] <= word;
    end
  end

  always_ff @(posedge avl_clk) begin
    if (avl_reset || clear) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      almost_full <= 1'b0;
    end else begin
      if (word_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({word_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // one cycle behind count, the threshold leaves room for that
      almost_full <= (count >= CNT_W'(`DACFIFO_BUF_ALMOST_FULL));
    end
  end

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);

endmodule

//--- hw/dacfifo_beat_packer.sv
// ******************************************************************
// packs accepted dma beats into wide words, lane 0 first
// the word is pushed on the edge of the beat that completes it
// ******************************************************************

`include "dacfifo_defines.svh"

module dacfifo_beat_packer (
  input  logic                           avl_clk,
  input  logic                           avl_reset,
  input  logic                           clear,
  input  logic                           beat_en,
  input  dacfifo_stream_pkg::dma_beat_t  dma_beat,
  output dacfifo_stream_pkg::fifo_word_t word,
  output logic                           word_push
);

  localparam int BEAT_W = `DACFIFO_DMA_DATA_WIDTH;
  localparam int RATIO  = `DACFIFO_MEM_RATIO;

  logic [`DACFIFO_BEAT_INDEX_WIDTH-1:0] lane;
  logic [`DACFIFO_AVL_DATA_WIDTH-1:0]   acc;
  logic                                 lane_full;

  assign lane_full = (lane == RATIO - 1);
  assign word_push = beat_en & (lane_full | dma_beat.last);

  // current beat is merged in directly so no extra cycle is spent
  always_comb begin
    word.data = acc;
    word.data[lane*BEAT_W +: BEAT_W] = dma_beat.data;
    word.last = dma_beat.last;
    word.last_index = lane;
  end

  always_ff @(posedge avl_clk) begin
    if (avl_reset || clear) begin
      lane <= '0;
    end else if (word_push) begin
      lane <= '0;
    end else if (beat_en) begin
      lane <= lane + 1'b1;
    end
  end

  // stale lanes of a short last word are masked by the byte enable
  always_ff @(posedge avl_clk) begin
    if (beat_en) begin
      acc[lane*BEAT_W +: BEAT_W] <= dma_beat.data;
    end
  end

endmodule

//--- hw/dacfifo_avl_pkg.sv
// ******************************************************************
// types for the avalon write command and the last-write record
// ******************************************************************

`include "dacfifo_defines.svh"

package dacfifo_avl_pkg;

  // single-beat avalon write, burst count is always one
  typedef struct packed {
    logic [`DACFIFO_AVL_ADDRESS_WIDTH-1:0] address;
    logic [`DACFIFO_AVL_DATA_WIDTH-1:0]    data;
    logic [`DACFIFO_AVL_BYTE_WIDTH-1:0]    byteenable;
  } avl_cmd_t;

  // where the final word of a transfer went, for the reader side
  typedef struct packed {
    logic [`DACFIFO_AVL_ADDRESS_WIDTH-1:0] address;
    logic [`DACFIFO_AVL_BYTE_WIDTH-1:0]    byteenable;
  } avl_last_t;

endpackage

//--- hw/dacfifo_stream_pkg.sv
// ******************************************************************
// types for the dma beat stream and the packed buffer words
// used by the packer, the word buffer and the avalon writer
// ******************************************************************

`include "dacfifo_defines.svh"

package dacfifo_stream_pkg;

  // one narrow sample beat from the dma
  typedef struct packed {
    logic [`DACFIFO_DMA_DATA_WIDTH-1:0] data;
    logic                               last;
  } dma_beat_t;

  // one wide word as held in the buffer
  // lane 0 sits in the low bits of data
  typedef struct packed {
    logic [`DACFIFO_AVL_DATA_WIDTH-1:0]   data;
    logic                                 last;
    // lane of the final valid beat, meaningful only with last set
    logic [`DACFIFO_BEAT_INDEX_WIDTH-1:0] last_index;
  } fifo_word_t;

endpackage

//--- hw/dacfifo_defines.svh
// ******************************************************************
// shared sizes and constants for the DAC buffer write path
// include wherever a width, depth or address constant is needed
// ******************************************************************

`ifndef DACFIFO_DEFINES_SVH
`define DACFIFO_DEFINES_SVH

// stream widths, 8 dma beats per avalon word
`define DACFIFO_DMA_DATA_WIDTH     64
`define DACFIFO_AVL_DATA_WIDTH     512
`define DACFIFO_MEM_RATIO          8
`define DACFIFO_BEAT_INDEX_WIDTH   3

// avalon side
`define DACFIFO_AVL_ADDRESS_WIDTH  25
`define DACFIFO_AVL_BYTE_WIDTH     64
`define DACFIFO_AVL_BASE_ADDRESS   0
// small limit so the wrap is reachable in simulation
`define DACFIFO_AVL_ADDRESS_LIMIT  19

// word buffer
`define DACFIFO_BUF_DEPTH          16
`define DACFIFO_BUF_ALMOST_FULL    14

`endif
